/* source/cpu_pkg.sv */
package cpu_pkg;

	// major opcodes
	typedef enum logic [5:0] {
		LWI     = 6'b000010,
		LWIBI   = 6'b000110,
		SWI     = 6'b001010,
		SWIBI   = 6'b001110,
		TY_LS   = 6'b011100,
		TY_BASE = 6'b100000,
		MOVI    = 6'b100010,
		SETHI   = 6'b100011,
		TY_J    = 6'b100100,
		TY_JR   = 6'b100101,
		TY_B    = 6'b100110,
		TY_BZ   = 6'b100111,
		ADDI    = 6'b101000,
		SUBRI   = 6'b101001,
		ANDI    = 6'b101010,
		XORI    = 6'b101011,
		ORI     = 6'b101100
	} opcode_t;

	// TY_BASE sub-ops, also the ALU operation code
	typedef enum logic [4:0] {
		ADD   = 5'b00000,
		SUB   = 5'b00001,
		AND   = 5'b00010,
		XOR   = 5'b00011,
		OR    = 5'b00100,
		SLTS  = 5'b00110,
		SLT   = 5'b00111,
		SLLI  = 5'b01000,
		SRLI  = 5'b01001,
		ROTRI = 5'b01011,
		SLL   = 5'b01100,
		SRL   = 5'b01101
	} sub_base_t;

	typedef enum logic [7:0] {
		LW = 8'b00000010,
		SW = 8'b00001010
	} sub_ls_t;

	typedef enum logic [1:0] {
		BGEZ = 2'b00,
		BLTZ = 2'b01,
		BEQZ = 2'b10,
		BNEZ = 2'b11
	} sub_bz_t;

	localparam logic B_BEQ = 1'b0;
	localparam logic B_BNE = 1'b1;
	localparam logic J_JAL = 1'b1;
	localparam logic [4:0] JR_JRAL = 5'b00001;

	typedef enum logic [2:0] {
		ALUSRC2_RBDATA  = 3'd0,
		ALUSRC2_IMM     = 3'd1,
		ALUSRC2_LSWI    = 3'd2,
		ALUSRC2_LSW     = 3'd3,
		ALUSRC2_BENX    = 3'd4,
		ALUSRC2_UNKNOWN = 3'd7
	} alu_src2_t;

	typedef enum logic [2:0] {
		IMM_5BIT_ZE  = 3'd0,
		IMM_15BIT_ZE = 3'd1,
		IMM_15BIT_SE = 3'd2,
		IMM_20BIT_SE = 3'd3,
		IMM_20BIT_HI = 3'd4,
		IMM_UNKNOWN  = 3'd7
	} imm_ext_t;

	typedef enum logic {
		MADDR_ALURESULT = 1'b0,
		MADDR_RADATA    = 1'b1
	} mem_addr_t;

	// only two encodings fit in one bit
	localparam mem_addr_t MADDR_UNKNOWN = MADDR_ALURESULT;

	typedef enum logic {
		WRADDR_RT = 1'b0,
		WRADDR_LP = 1'b1
	} wr_addr_t;

	typedef enum logic [1:0] {
		WRREG_ALURESULT = 2'd0,
		WRREG_IMMDATA   = 2'd1,
		WRREG_MEM       = 2'd2,
		WRREG_PC        = 2'd3
	} wr_reg_t;

	localparam logic [4:0] LP_REG = 5'd30;

	// instruction fields
	localparam int OPCODE_HI = 30;
	localparam int OPCODE_LO = 25;
	localparam int RT_HI = 24;
	localparam int RT_LO = 20;
	localparam int RA_HI = 19;
	localparam int RA_LO = 15;
	localparam int RB_HI = 14;
	localparam int RB_LO = 10;
	localparam int SUB_BASE_HI = 4;
	localparam int SUB_BASE_LO = 0;
	localparam int SUB_LS_HI = 7;
	localparam int SUB_LS_LO = 0;
	localparam int SUB_B_BIT = 14;
	localparam int SUB_BZ_HI = 17;
	localparam int SUB_BZ_LO = 16;
	localparam int IMM15_HI = 14;
	localparam int IMM15_LO = 0;
	localparam int IMM20_HI = 19;
	localparam int IMM20_LO = 0;
	localparam int SUB_J_BIT = 24;
	localparam int IMM24_HI = 23;
	localparam int IMM24_LO = 0;
	localparam int SUB_JR_HI = 4;
	localparam int SUB_JR_LO = 0;
	localparam int BOFF_HI = 13;
	localparam int BOFF_LO = 0;
	localparam int BZOFF_HI = 15;
	localparam int BZOFF_LO = 0;

endpackage

/* source/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if;
	import cpu_pkg::*;

	alu_src2_t select_alu_src2;
	imm_ext_t select_imm_extend;
	mem_addr_t select_mem_addr;
	wr_addr_t select_write_reg_addr;
	wr_reg_t select_write_reg;

	logic do_reg_write;
	logic do_ra_write;
	logic do_dm_read;
	logic do_dm_write;

	// comparison flags on rt and ra
	logic reg_rt_ra_equal;
	logic reg_rt_zero;
	logic reg_rt_negative;

	modport controller (
		output select_alu_src2, select_imm_extend, select_mem_addr,
		output select_write_reg_addr, select_write_reg,
		output do_reg_write, do_ra_write, do_dm_read, do_dm_write,
		output reg_rt_ra_equal, reg_rt_zero, reg_rt_negative
	);

	modport datapath (
		input select_alu_src2, select_imm_extend, select_mem_addr,
		input select_write_reg_addr, select_write_reg,
		input do_reg_write, do_ra_write, do_dm_read, do_dm_write,
		input reg_rt_ra_equal, reg_rt_zero, reg_rt_negative
	);

endinterface

/* source/controller.sv */
`timescale 1ns/1ps

module controller (
	input  logic               clock,
	input  logic               rst,
	input  cpu_pkg::opcode_t   opcode,
	input  cpu_pkg::sub_base_t sub_op_base,
	input  cpu_pkg::sub_ls_t   sub_op_ls,
	input  logic               sub_op_j,
	input  logic [4:0]         sub_op_jr,
	input  logic [31:0]        reg_rt_data,
	input  logic [31:0]        reg_ra_data,
	output logic               do_im_read,
	output logic               do_im_write,
	ctrl_if.controller         ctrl
);
	import cpu_pkg::*;

	logic dm_read_dec;
	logic dm_write_dec;

	assign do_im_read = ~rst;
	// no instruction memory writes in this core
	assign do_im_write = 1'b0;

	assign ctrl.reg_rt_ra_equal = (reg_rt_data == reg_ra_data);
	assign ctrl.reg_rt_zero = ~(|reg_rt_data);
	assign ctrl.reg_rt_negative = reg_rt_data[31];

	// data memory strobes stay low in reset
	assign ctrl.do_dm_read = dm_read_dec & ~rst;
	assign ctrl.do_dm_write = dm_write_dec & ~rst;

	always_comb begin
		ctrl.select_alu_src2 = ALUSRC2_UNKNOWN;
		ctrl.select_imm_extend = IMM_UNKNOWN;
		ctrl.select_mem_addr = MADDR_UNKNOWN;
		ctrl.select_write_reg_addr = WRADDR_RT;
		ctrl.select_write_reg = WRREG_ALURESULT;
		ctrl.do_reg_write = 1'b0;
		ctrl.do_ra_write = 1'b0;
		dm_read_dec = 1'b0;
		dm_write_dec = 1'b0;
		case (opcode)
			TY_BASE: begin
				case (sub_op_base)
					ADD, SUB, AND, OR, XOR, SLT, SLTS, SRL, SLL: begin
						ctrl.select_alu_src2 = ALUSRC2_RBDATA;
						ctrl.do_reg_write = 1'b1;
					end
					SRLI, SLLI, ROTRI: begin
						ctrl.select_alu_src2 = ALUSRC2_IMM;
						ctrl.select_imm_extend = IMM_5BIT_ZE;
						ctrl.do_reg_write = 1'b1;
					end
					default: begin
					end
				endcase
			end
			ADDI, SUBRI: begin
				ctrl.select_alu_src2 = ALUSRC2_IMM;
				ctrl.select_imm_extend = IMM_15BIT_SE;
				ctrl.do_reg_write = 1'b1;
			end
			ANDI, ORI, XORI: begin
				ctrl.select_alu_src2 = ALUSRC2_IMM;
				ctrl.select_imm_extend = IMM_15BIT_ZE;
				ctrl.do_reg_write = 1'b1;
			end
			MOVI, SETHI: begin
				ctrl.select_imm_extend = (opcode == MOVI) ? IMM_20BIT_SE : IMM_20BIT_HI;
				ctrl.select_write_reg = WRREG_IMMDATA;
				ctrl.do_reg_write = 1'b1;
			end
			LWI, LWIBI: begin
				ctrl.select_alu_src2 = ALUSRC2_LSWI;
				ctrl.select_mem_addr = (opcode == LWIBI) ? MADDR_RADATA : MADDR_ALURESULT;
				ctrl.select_write_reg = WRREG_MEM;
				ctrl.do_reg_write = 1'b1;
				ctrl.do_ra_write = (opcode == LWIBI);
				dm_read_dec = 1'b1;
			end
			SWI, SWIBI: begin
				ctrl.select_alu_src2 = ALUSRC2_LSWI;
				ctrl.select_mem_addr = (opcode == SWIBI) ? MADDR_RADATA : MADDR_ALURESULT;
				ctrl.do_ra_write = (opcode == SWIBI);
				dm_write_dec = 1'b1;
			end
			TY_LS: begin
				case (sub_op_ls)
					LW: begin
						ctrl.select_alu_src2 = ALUSRC2_LSW;
						ctrl.select_mem_addr = MADDR_ALURESULT;
						ctrl.select_write_reg = WRREG_MEM;
						ctrl.do_reg_write = 1'b1;
						dm_read_dec = 1'b1;
					end
					SW: begin
						ctrl.select_alu_src2 = ALUSRC2_LSW;
						ctrl.select_mem_addr = MADDR_ALURESULT;
						dm_write_dec = 1'b1;
					end
					default: begin
					end
				endcase
			end
			TY_B: ctrl.select_alu_src2 = ALUSRC2_BENX;
			TY_J: begin
				// plain J writes nothing
				if (sub_op_j == J_JAL) begin
					ctrl.select_write_reg_addr = WRADDR_LP;
					ctrl.select_write_reg = WRREG_PC;
					ctrl.do_reg_write = 1'b1;
				end
			end
			TY_JR: begin
				if (sub_op_jr == JR_JRAL) begin
					ctrl.select_write_reg = WRREG_PC;
					ctrl.do_reg_write = 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

	// a store and a load never share one cycle on the data bus
	dm_exclusive: assert property (@(posedge clock) disable iff (rst)
		!(ctrl.do_dm_read && ctrl.do_dm_write));

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
	input  logic [31:0]        src1,
	input  logic [31:0]        src2,
	input  cpu_pkg::sub_base_t op,
	output logic [31:0]        result
);
	import cpu_pkg::*;

	logic [4:0] shamt;
	logic [63:0] rot;

	assign shamt = src2[4:0];
	// doubled word, shifted right, gives the rotate in the low half
	assign rot = {src1, src1} >> shamt;

	always_comb begin
		case (op)
			ADD:
				result = src1 + src2;
			SUB:
				result = src1 - src2;
			AND:
				result = src1 & src2;
			OR:
				result = src1 | src2;
			XOR:
				result = src1 ^ src2;
			SLT:
				result = {31'b0, src1 < src2};
			SLTS:
				result = {31'b0, $signed(src1) < $signed(src2)};
			SRL, SRLI:
				result = src1 >> shamt;
			SLL, SLLI:
				result = src1 << shamt;
			ROTRI:
				result = rot[31:0];
			default:
				result = '0;
		endcase
	end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file (
	input  logic        clock,
	input  logic        rst,
	input  logic [4:0]  ra_addr,
	input  logic [4:0]  rb_addr,
	input  logic [4:0]  rt_addr,
	input  logic [4:0]  wr_addr,
	input  logic [31:0] wr_data,
	input  logic        wr_en,
	input  logic [4:0]  base_addr,
	input  logic [31:0] base_data,
	input  logic        base_en,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data,
	output logic [31:0] rt_data
);

	logic [31:0] regs [32];

	// r0 reads as zero whatever is stored
	assign ra_data = (ra_addr == 5'd0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == 5'd0) ? '0 : regs[rb_addr];
	assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else begin
			if (wr_en && wr_addr != 5'd0)
				regs[wr_addr] <= wr_data;
			// base update for lwi.bi / swi.bi
			if (base_en && base_addr != 5'd0)
				regs[base_addr] <= base_data;
		end
	end

	write_port_clash: assert property (@(posedge clock) disable iff (rst)
		!(wr_en && base_en && wr_addr == base_addr && wr_addr != 5'd0));

endmodule

/* source/datapath.sv */
`timescale 1ns/1ps

module datapath #(
	parameter int PC_WIDTH = 32
) (
	input  logic                  clock,
	input  logic                  rst,
	input  logic [31:0]           instr,
	input  logic [31:0]           dm_rdata,
	input  logic [31:0]           alu_result,
	input  logic [31:0]           ra_data,
	input  logic [31:0]           rb_data,
	input  logic [31:0]           rt_data,
	ctrl_if.datapath              ctrl,
	output logic [PC_WIDTH-1:0]   pc,
	output cpu_pkg::opcode_t      opcode,
	output cpu_pkg::sub_base_t    sub_op_base,
	output cpu_pkg::sub_ls_t      sub_op_ls,
	output logic                  sub_op_j,
	output logic [4:0]            sub_op_jr,
	output logic [4:0]            ra_addr,
	output logic [4:0]            rb_addr,
	output logic [4:0]            rt_addr,
	output logic [31:0]           alu_src1,
	output logic [31:0]           alu_src2,
	output cpu_pkg::sub_base_t    alu_op,
	output logic [4:0]            wr_addr,
	output logic [31:0]           wr_data,
	output logic [31:0]           base_data,
	output logic [31:0]           dm_addr,
	output logic [31:0]           dm_wdata
);
	import cpu_pkg::*;

	logic [PC_WIDTH-1:0] pc_plus4;
	logic [PC_WIDTH-1:0] pc_next;
	logic [31:0] imm_ext;
	logic [31:0] src2_mux;
	logic [31:0] imm15_se;
	logic signed [31:0] b_off;
	logic signed [31:0] bz_off;
	logic signed [31:0] j_off;
	logic take_b;
	logic take_bz;
	sub_bz_t sub_op_bz;

	assign opcode = opcode_t'(instr[OPCODE_HI:OPCODE_LO]);
	assign sub_op_base = sub_base_t'(instr[SUB_BASE_HI:SUB_BASE_LO]);
	assign sub_op_ls = sub_ls_t'(instr[SUB_LS_HI:SUB_LS_LO]);
	assign sub_op_j = instr[SUB_J_BIT];
	assign sub_op_jr = instr[SUB_JR_HI:SUB_JR_LO];
	assign sub_op_bz = sub_bz_t'(instr[SUB_BZ_HI:SUB_BZ_LO]);
	assign ra_addr = instr[RA_HI:RA_LO];
	assign rb_addr = instr[RB_HI:RB_LO];
	assign rt_addr = instr[RT_HI:RT_LO];

	assign imm15_se = 32'($signed(instr[IMM15_HI:IMM15_LO]));
	assign b_off = 32'($signed(instr[BOFF_HI:BOFF_LO])) <<< 2;
	assign bz_off = 32'($signed(instr[BZOFF_HI:BZOFF_LO])) <<< 2;
	assign j_off = 32'($signed(instr[IMM24_HI:IMM24_LO])) <<< 1;

	always_comb begin
		case (ctrl.select_imm_extend)
			IMM_5BIT_ZE:  imm_ext = {27'b0, instr[RB_HI:RB_LO]};
			IMM_15BIT_ZE: imm_ext = 32'(instr[IMM15_HI:IMM15_LO]);
			IMM_15BIT_SE: imm_ext = imm15_se;
			IMM_20BIT_SE: imm_ext = 32'($signed(instr[IMM20_HI:IMM20_LO]));
			IMM_20BIT_HI: imm_ext = {instr[IMM20_HI:IMM20_LO], 12'b0};
			default:      imm_ext = '0;
		endcase
	end

	always_comb begin
		case (ctrl.select_alu_src2)
			ALUSRC2_RBDATA: src2_mux = rb_data;
			ALUSRC2_IMM:    src2_mux = imm_ext;
			ALUSRC2_LSWI:   src2_mux = imm15_se << 2;
			ALUSRC2_LSW:    src2_mux = rb_data << 2;
			ALUSRC2_BENX:   src2_mux = rb_data;
			default:        src2_mux = '0;
		endcase
	end

	// subri is imm minus ra, so the operands swap
	assign alu_src1 = (opcode == SUBRI) ? src2_mux : ra_data;
	assign alu_src2 = (opcode == SUBRI) ? ra_data : src2_mux;

	always_comb begin
		case (opcode)
			TY_BASE: alu_op = sub_op_base;
			SUBRI:   alu_op = SUB;
			ANDI:    alu_op = AND;
			ORI:     alu_op = OR;
			XORI:    alu_op = XOR;
			default: alu_op = ADD;
		endcase
	end

	assign pc_plus4 = pc + PC_WIDTH'(4);

	assign wr_addr = (ctrl.select_write_reg_addr == WRADDR_LP) ? LP_REG : rt_addr;

	always_comb begin
		case (ctrl.select_write_reg)
			WRREG_IMMDATA: wr_data = imm_ext;
			WRREG_MEM:     wr_data = dm_rdata;
			WRREG_PC:      wr_data = 32'(pc_plus4);
			default:       wr_data = alu_result;
		endcase
	end

	// old ra addresses memory, ra plus offset goes back to ra
	assign base_data = alu_result;
	assign dm_addr = (ctrl.select_mem_addr == MADDR_RADATA) ? ra_data : alu_result;
	assign dm_wdata = rt_data;

	always_comb begin
		case (instr[SUB_B_BIT])
			B_BEQ:   take_b = ctrl.reg_rt_ra_equal;
			B_BNE:   take_b = ~ctrl.reg_rt_ra_equal;
			default: take_b = 1'b0;
		endcase
		case (sub_op_bz)
			BEQZ:    take_bz = ctrl.reg_rt_zero;
			BNEZ:    take_bz = ~ctrl.reg_rt_zero;
			BGEZ:    take_bz = ~ctrl.reg_rt_negative;
			BLTZ:    take_bz = ctrl.reg_rt_negative;
			default: take_bz = 1'b0;
		endcase
	end

	always_comb begin
		pc_next = pc_plus4;
		case (opcode)
			TY_B:
				if (take_b)
					pc_next = pc + PC_WIDTH'(b_off);
			TY_BZ:
				if (take_bz)
					pc_next = pc + PC_WIDTH'(bz_off);
			TY_J:
				pc_next = pc + PC_WIDTH'(j_off);
			TY_JR:
				if (sub_op_jr == JR_JRAL)
					pc_next = PC_WIDTH'(rb_data);
			default: begin
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst)
			pc <= '0;
		else
			pc <= pc_next;
	end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
	parameter int PC_WIDTH = 32
) (
	input  logic                clock,
	input  logic                rst,
	input  logic [31:0]         im_data,
	input  logic [31:0]         dm_rdata,
	output logic [PC_WIDTH-1:0] im_addr,
	output logic                im_read,
	output logic                im_write,
	output logic [31:0]         dm_addr,
	output logic [31:0]         dm_wdata,
	output logic                dm_read,
	output logic                dm_write
);
	import cpu_pkg::*;

	opcode_t opcode;
	sub_base_t sub_op_base;
	sub_ls_t sub_op_ls;
	sub_base_t alu_op;
	logic sub_op_j;
	logic [4:0] sub_op_jr;
	logic [4:0] ra_addr;
	logic [4:0] rb_addr;
	logic [4:0] rt_addr;
	logic [4:0] wr_addr;
	logic [31:0] ra_data;
	logic [31:0] rb_data;
	logic [31:0] rt_data;
	logic [31:0] wr_data;
	logic [31:0] base_data;
	logic [31:0] alu_src1;
	logic [31:0] alu_src2;
	logic [31:0] alu_result;

	ctrl_if ctrl ();

	assign dm_read = ctrl.do_dm_read;
	assign dm_write = ctrl.do_dm_write;

	controller u_controller (
		.clock(clock), .rst(rst),
		.opcode(opcode), .sub_op_base(sub_op_base), .sub_op_ls(sub_op_ls),
		.sub_op_j(sub_op_j), .sub_op_jr(sub_op_jr),
		.reg_rt_data(rt_data), .reg_ra_data(ra_data),
		.do_im_read(im_read), .do_im_write(im_write),
		.ctrl(ctrl.controller)
	);

	datapath #(.PC_WIDTH(PC_WIDTH)) u_datapath (
		.clock(clock), .rst(rst), .instr(im_data), .dm_rdata(dm_rdata),
		.alu_result(alu_result), .ra_data(ra_data), .rb_data(rb_data),
		.rt_data(rt_data), .ctrl(ctrl.datapath), .pc(im_addr),
		.opcode(opcode), .sub_op_base(sub_op_base), .sub_op_ls(sub_op_ls),
		.sub_op_j(sub_op_j), .sub_op_jr(sub_op_jr),
		.ra_addr(ra_addr), .rb_addr(rb_addr), .rt_addr(rt_addr),
		.alu_src1(alu_src1), .alu_src2(alu_src2), .alu_op(alu_op),
		.wr_addr(wr_addr), .wr_data(wr_data), .base_data(base_data),
		.dm_addr(dm_addr), .dm_wdata(dm_wdata)
	);

	alu u_alu (
		.src1(alu_src1), .src2(alu_src2), .op(alu_op), .result(alu_result)
	);

	// base write port always targets ra
	register_file u_register_file (
		.clock(clock), .rst(rst),
		.ra_addr(ra_addr), .rb_addr(rb_addr), .rt_addr(rt_addr),
		.wr_addr(wr_addr), .wr_data(wr_data), .wr_en(ctrl.do_reg_write),
		.base_addr(ra_addr), .base_data(base_data), .base_en(ctrl.do_ra_write),
		.ra_data(ra_data), .rb_data(rb_data), .rt_data(rt_data)
	);

endmodule

/* tests/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	localparam logic [31:0] A_VAL = 32'hfff8_1234;
	localparam logic [31:0] B_VAL = 32'h1234_5678;
	// j to itself
	localparam logic [31:0] HALT = {1'b0, TY_J, 1'b0, 24'd0};

	logic clock;
	logic rst;
	logic [31:0] im_data;
	logic [31:0] dm_rdata;
	logic [31:0] im_addr;
	logic im_read;
	logic im_write;
	logic [31:0] dm_addr;
	logic [31:0] dm_wdata;
	logic dm_read;
	logic dm_write;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] dinit [256];
	logic [31:0] prog [256];
	logic [31:0] exp_addr [64];
	logic [31:0] exp_data [64];
	string case_name [8];
	int case_start [8];
	int case_len [8];
	int case_exp [8];
	int case_nexp [8];
	int n_prog;
	int n_exp;
	int n_case;
	int cycles;
	int limit;
	int seed;

	cpu_top #(.PC_WIDTH(32)) uut (
		.clock(clock), .rst(rst), .im_data(im_data), .dm_rdata(dm_rdata),
		.im_addr(im_addr), .im_read(im_read), .im_write(im_write),
		.dm_addr(dm_addr), .dm_wdata(dm_wdata), .dm_read(dm_read), .dm_write(dm_write)
	);

	// word-addressed memories, combinational read
	// no data without the read strobe
	assign im_data = im_read ? imem[im_addr[9:2]] : 'x;
	assign dm_rdata = dm_read ? dmem[dm_addr[9:2]] : 'x;

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: the expected stores did not arrive within %0d cycles", limit);
			$display("=== FAIL ===");
			$fatal(1, "simulation timed out");
		end
	end

	function automatic logic [31:0] r_type(input logic [5:0] op, input int rt, input int ra,
			input int rb, input logic [4:0] sub);
		return {1'b0, op, 5'(rt), 5'(ra), 5'(rb), 5'b0, sub};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input int rt, input int ra,
			input logic [14:0] imm);
		return {1'b0, op, 5'(rt), 5'(ra), imm};
	endfunction

	function automatic logic [31:0] u_type(input logic [5:0] op, input int rt,
			input logic [19:0] imm);
		return {1'b0, op, 5'(rt), imm};
	endfunction

	function automatic logic [31:0] bz_type(input int rt, input logic [1:0] sub,
			input logic [15:0] off);
		return {1'b0, TY_BZ, 5'(rt), 2'b0, sub, off};
	endfunction

	function automatic logic [31:0] j_type(input logic sub, input logic [23:0] imm);
		return {1'b0, TY_J, sub, imm};
	endfunction

	task automatic check(input string name, input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error %s %s: expected %h, actual %h", name, what, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic add_instr(input logic [31:0] word);
		prog[n_prog] = word;
		n_prog++;
	endtask

	task automatic add_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr[n_exp] = addr;
		exp_data[n_exp] = data;
		n_exp++;
	endtask

	task automatic open_case(input string name);
		case_name[n_case] = name;
		case_start[n_case] = n_prog;
		case_exp[n_case] = n_exp;
	endtask

	task automatic close_case();
		add_instr(HALT);
		case_len[n_case] = n_prog - case_start[n_case];
		case_nexp[n_case] = n_exp - case_exp[n_case];
		n_case++;
	endtask

	// op leaves its result in r4, then r4 goes to a word slot
	task automatic op_store(input logic [31:0] word, input int slot, input logic [31:0] expected);
		add_instr(word);
		add_instr(i_type(SWI, 4, 0, 15'(slot)));
		add_store(32'(slot * 4), expected);
	endtask

	// branch offset of two words skips the store right after it
	task automatic branch_store(input logic [31:0] word, input logic taken, input int rt,
			input int slot, input logic [31:0] value);
		add_instr(word);
		add_instr(i_type(SWI, rt, 0, 15'(slot)));
		if (!taken)
			add_store(32'(slot * 4), value);
	endtask

	// r1 = A_VAL, r2 = B_VAL, r3 = 5
	task automatic load_operands();
		add_instr(u_type(MOVI, 1, 20'h81234));
		add_instr(u_type(SETHI, 2, 20'h12345));
		add_instr(i_type(ORI, 2, 2, 15'h0678));
		add_instr(u_type(MOVI, 3, 20'd5));
	endtask

	task automatic build_tests();
		open_case("alu_reg");
		load_operands();
		op_store(r_type(TY_BASE, 4, 1, 2, ADD), 0, A_VAL + B_VAL);
		op_store(r_type(TY_BASE, 4, 1, 2, SUB), 1, A_VAL - B_VAL);
		op_store(r_type(TY_BASE, 4, 1, 2, AND), 2, A_VAL & B_VAL);
		op_store(r_type(TY_BASE, 4, 1, 2, OR), 3, A_VAL | B_VAL);
		op_store(r_type(TY_BASE, 4, 1, 2, XOR), 4, A_VAL ^ B_VAL);
		op_store(r_type(TY_BASE, 4, 1, 2, SLT), 5, 32'd0);
		op_store(r_type(TY_BASE, 4, 1, 2, SLTS), 6, 32'd1);
		op_store(r_type(TY_BASE, 4, 1, 3, SRL), 7, A_VAL >> 5);
		op_store(r_type(TY_BASE, 4, 1, 3, SLL), 8, A_VAL << 5);
		close_case();

		open_case("alu_imm");
		load_operands();
		op_store(r_type(TY_BASE, 4, 1, 7, SRLI), 10, A_VAL >> 7);
		op_store(r_type(TY_BASE, 4, 1, 7, SLLI), 11, A_VAL << 7);
		op_store(r_type(TY_BASE, 4, 1, 7, ROTRI), 12, (A_VAL >> 7) | (A_VAL << 25));
		op_store(i_type(ADDI, 4, 1, 15'h7ff0), 13, A_VAL - 32'd16);
		op_store(i_type(SUBRI, 4, 1, 15'h0100), 14, 32'h100 - A_VAL);
		op_store(i_type(ANDI, 4, 2, 15'h7f0f), 15, B_VAL & 32'h7f0f);
		op_store(i_type(ORI, 4, 1, 15'h4321), 16, A_VAL | 32'h4321);
		op_store(i_type(XORI, 4, 2, 15'h7fff), 17, B_VAL ^ 32'h7fff);
		close_case();

		// ls sub-ops have zero in bits 7:5
		open_case("load_store");
		add_instr(u_type(MOVI, 5, 20'h00040));
		add_instr(u_type(MOVI, 7, 20'd2));
		add_instr(i_type(LWI, 6, 5, 15'd3));
		add_instr(r_type(TY_LS, 8, 5, 7, 5'(LW)));
		add_instr(i_type(SWI, 6, 0, 15'd100));
		add_instr(i_type(SWI, 6, 5, 15'd5));
		add_instr(r_type(TY_LS, 8, 0, 5, 5'(SW)));
		add_store(32'd400, dinit[19]);
		add_store(32'h54, dinit[19]);
		add_store(32'h100, dinit[18]);
		close_case();

		open_case("base_update");
		add_instr(u_type(MOVI, 5, 20'h00080));
		add_instr(i_type(LWIBI, 6, 5, 15'd2));
		add_instr(i_type(SWI, 6, 0, 15'd120));
		add_instr(i_type(SWI, 5, 0, 15'd121));
		add_instr(i_type(SWIBI, 6, 5, 15'h7fff));
		add_instr(i_type(SWI, 5, 0, 15'd122));
		add_store(32'd480, dinit[32]);
		add_store(32'd484, 32'h88);
		add_store(32'h88, dinit[32]);
		add_store(32'd488, 32'h84);
		close_case();

		open_case("branch");
		add_instr(u_type(MOVI, 1, 20'd7));
		add_instr(u_type(MOVI, 2, 20'd7));
		add_instr(u_type(MOVI, 3, 20'hfffff));
		branch_store(i_type(TY_B, 1, 2, {B_BEQ, 14'd2}), 1'b1, 1, 50, 32'd7);
		branch_store(i_type(TY_B, 1, 2, {B_BNE, 14'd2}), 1'b0, 1, 51, 32'd7);
		branch_store(i_type(TY_B, 1, 3, {B_BEQ, 14'd2}), 1'b0, 3, 52, 32'hffff_ffff);
		branch_store(i_type(TY_B, 1, 3, {B_BNE, 14'd2}), 1'b1, 3, 53, 32'hffff_ffff);
		branch_store(bz_type(0, BEQZ, 16'd2), 1'b1, 1, 54, 32'd7);
		branch_store(bz_type(1, BEQZ, 16'd2), 1'b0, 1, 55, 32'd7);
		branch_store(bz_type(1, BNEZ, 16'd2), 1'b1, 1, 56, 32'd7);
		branch_store(bz_type(0, BNEZ, 16'd2), 1'b0, 1, 57, 32'd7);
		branch_store(bz_type(1, BGEZ, 16'd2), 1'b1, 1, 58, 32'd7);
		branch_store(bz_type(3, BGEZ, 16'd2), 1'b0, 3, 59, 32'hffff_ffff);
		branch_store(bz_type(3, BLTZ, 16'd2), 1'b1, 3, 60, 32'hffff_ffff);
		branch_store(bz_type(1, BLTZ, 16'd2), 1'b0, 1, 61, 32'd7);
		close_case();

		// skipped slots would store r0
		open_case("jump");
		add_instr(j_type(1'b0, 24'd4));
		add_instr(i_type(SWI, 0, 0, 15'd70));
		add_instr(j_type(J_JAL, 24'd4));
		add_instr(i_type(SWI, 0, 0, 15'd71));
		add_instr(i_type(SWI, 30, 0, 15'd72));
		add_instr(u_type(MOVI, 9, 20'd36));
		add_instr(r_type(TY_JR, 10, 0, 9, JR_JRAL));
		add_instr(i_type(SWI, 0, 0, 15'd73));
		add_instr(i_type(SWI, 0, 0, 15'd74));
		add_instr(i_type(SWI, 10, 0, 15'd75));
		add_store(32'd288, 32'd12);
		add_store(32'd300, 32'd28);
		close_case();
	endtask

	task automatic run_case(input int c);
		int seen;
		logic [31:0] st_addr;
		logic [31:0] st_data;
		@(posedge clock);
		#1 rst = 1'b1;
		for (int i = 0; i < case_len[c]; i++)
			imem[i] = prog[case_start[c] + i];
		for (int i = 0; i < 256; i++)
			dmem[i] = dinit[i];
		repeat (8) begin
			@(negedge clock);
			check(case_name[c], "reset strobes", 32'd0,
				{28'd0, im_write, im_read, dm_read, dm_write});
		end
		@(posedge clock);
		#1 rst = 1'b0;
		check(case_name[c], "first pc", 32'd0, im_addr);
		seen = 0;
		while (seen < case_nexp[c]) begin
			@(negedge clock);
			if (dm_write) begin
				st_addr = dm_addr;
				st_data = dm_wdata;
				check(case_name[c], "store addr", exp_addr[case_exp[c] + seen], st_addr);
				check(case_name[c], "store data", exp_data[case_exp[c] + seen], st_data);
				seen++;
				@(posedge clock);
				#1 dmem[st_addr[9:2]] = st_data;
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		seed = 32'h2903_da37;
		for (int i = 0; i < 256; i++)
			dinit[i] = $random(seed);
		build_tests();
		// reset takes nine cycles per case, one spare
		limit = 4 * n_prog + 10 * n_case;
		for (int c = 0; c < n_case; c++)
			run_case(c);
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* list.f */
source/cpu_pkg.sv
source/ctrl_if.sv
source/controller.sv
source/alu.sv
source/register_file.sv
source/datapath.sv
source/cpu_top.sv
tests/cpu_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = cpu_tb
FILELIST = list.f
OBJ_DIR = obj_dir
PASS_MSG = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
